/* verilog/frame_wr_pkg.sv */
// shared widths and constants; single clock, up to 4 frames of 256 bursts of 16 words, 30-bit address
`default_nettype none

package frame_wr_pkg;

	// ----------------------------------------------------------------------
	// data path
	// ----------------------------------------------------------------------
	localparam int DATA_W = 32;                          // pixel and memory word
	typedef logic [DATA_W-1:0] pixel_t;

	localparam int BURST_LEN = 16;                       // words in a full burst
	typedef logic [$clog2(BURST_LEN+1)-1:0] burst_cnt_t; // 0 to 16
	typedef logic [5:0] burst_len_t;                     // controller bl field, count - 1

	// ----------------------------------------------------------------------
	// addressing
	// ----------------------------------------------------------------------
	localparam int BURST_ADDR_W = 8;                     // bursts per frame index
	typedef logic [BURST_ADDR_W-1:0] burst_addr_t;

	localparam int PTR_W = 2;                            // up to four frames
	typedef logic [PTR_W-1:0] frame_ptr_t;
	typedef logic [PTR_W:0] frame_depth_t;               // frames in use, 1 to 4
	localparam int DEPTH_DEFAULT = 2;                    // double buffer out of reset

	localparam int BYTE_ADDR_W = 30;
	typedef logic [BYTE_ADDR_W-1:0] byte_addr_t;
	localparam int BURST_BYTE_SHIFT = 6;                 // 16 words x 4 bytes

	// front fifo
	localparam int FIFO_DEPTH = 64;
	typedef logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_level_t;

	// burst writer states
	typedef enum logic [2:0] {
		ST_IDLE,     // wait for a burst worth of data
		ST_PTR,      // frame pointer being picked
		ST_WR,       // moving words to the controller
		ST_CMD_WAIT, // controller command fifo busy
		ST_CMD,      // write command out
		ST_CHK       // next burst or back to idle
	} burst_state_t;

endpackage

`default_nettype wire

/* verilog/frame_wr_front_fifo.sv */
// sync fwft fifo; dout comes from an async-read array, pixels dropped while full set a sticky flag
`timescale 1ns/1ps
`default_nettype none

module frame_wr_front_fifo
	import frame_wr_pkg::*;
(
	input  wire          clk,
	input  wire          reset,
	input  wire          i_flush,       // clears pointers, overflow too when disarmed
	input  wire          i_fval,
	input  wire          i_dval,
	input  wire          i_armed,
	input  wire  pixel_t i_data,
	input  wire          i_rd_en,       // pops the word at o_dout
	output pixel_t       o_dout,
	output logic         o_empty,
	output logic         o_burst_ready, // at least one full burst stored
	output logic         o_full,
	output logic         o_overflow
);

	pixel_t                        mem [FIFO_DEPTH];
	logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
	fifo_level_t                   level;     // words stored
	logic                          px_valid;  // pixel offered while armed
	logic                          wr_ok;
	logic                          rd_ok;

	assign px_valid = i_fval & i_dval & i_armed;
	assign wr_ok    = px_valid & ~o_full;
	assign rd_ok    = i_rd_en & ~o_empty; // guard against a pop on empty

	// ----------------------------------------------------------------------
	// storage
	// ----------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (wr_ok && !i_flush)
			mem[wr_ptr] <= i_data;
	end

	assign o_dout = mem[rd_ptr]; // fall through, valid while not empty

	// ----------------------------------------------------------------------
	// pointers and level
	// ----------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset || i_flush)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end
		else
		begin
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_ok)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_ok, rd_ok})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;    // none or both
			endcase
		end
	end

	assign o_empty       = (level == '0);
	assign o_full        = (level == fifo_level_t'(FIFO_DEPTH));
	assign o_burst_ready = (level >= fifo_level_t'(BURST_LEN));

	// sticky until reset or a flush while disarmed
	always_ff @(posedge clk)
	begin
		if (reset)
			o_overflow <= 1'b0;
		else if (i_flush && !i_armed)
			o_overflow <= 1'b0;
		else if (px_valid && o_full)
			o_overflow <= 1'b1; // pixel lost
	end

endmodule

`default_nettype wire

/* verilog/frame_wr_burst_ctrl.sv */
// burst writer; needs i_dval low for 3 cycles after each i_fval rise, since that rise flushes the fifo
`timescale 1ns/1ps
`default_nettype none

module frame_wr_burst_ctrl
	import frame_wr_pkg::*;
(
	input  wire                clk,
	input  wire                reset,
	input  wire                i_fval,
	input  wire                i_stream_en,
	input  wire  frame_depth_t i_frame_depth,
	input  wire                i_calib_done,   // async to clk
	input  wire                i_fifo_empty,
	input  wire                i_burst_ready,
	input  wire  pixel_t       i_fifo_data,
	input  wire                i_alloc_done,
	input  wire  frame_ptr_t   i_wr_ptr,
	input  wire                i_cmd_empty,
	input  wire                i_wr_full,
	output logic               o_armed,
	output frame_depth_t       o_depth,
	output logic               o_flush,
	output logic               o_rd_en,
	output logic               o_alloc_start,
	output logic               o_wr_en,
	output pixel_t             o_wr_data,
	output logic               o_cmd_en,
	output burst_len_t         o_cmd_bl,
	output byte_addr_t         o_cmd_byte_addr,
	output burst_addr_t        o_wr_addr       // last burst the controller accepted
);

	logic [1:0]   fval_q;      // fval history, [0] newest
	logic         fval_rise;
	logic [1:0]   calib_q;     // two flop sync
	burst_state_t state;
	burst_state_t state_nxt;
	burst_cnt_t   word_cnt;    // words in current burst
	burst_addr_t  burst_idx;   // burst number in frame
	burst_addr_t  cmd_idx;     // index of last issued command
	logic         cmd_pending; // command sent, not yet drained
	logic         cmd_empty_q;
	logic         cmd_drained;
	logic         frame_over;
	logic         burst_end;

	// ----------------------------------------------------------------------
	// housekeeping
	// ----------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			fval_q  <= '0;
			calib_q <= '0;
		end
		else
		begin
			fval_q  <= {fval_q[0], i_fval};
			calib_q <= {calib_q[0], i_calib_done};
		end
	end

	assign fval_rise = fval_q[0] & ~fval_q[1];

	// enable only counts from a frame start; depth only moves while stopped
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_armed <= 1'b0;
			o_depth <= frame_depth_t'(DEPTH_DEFAULT);
		end
		else
		begin
			if (!i_stream_en)
				o_armed <= 1'b0;
			else if (fval_rise)
				o_armed <= 1'b1;
			if (!i_stream_en)
				o_depth <= i_frame_depth;
		end
	end

	assign o_flush = fval_rise | ~o_armed; // fresh fifo per frame

	// ----------------------------------------------------------------------
	// burst fsm
	// ----------------------------------------------------------------------
	assign frame_over = ~fval_q[0] & i_fifo_empty;
	assign o_rd_en    = (state == ST_WR) & ~i_fifo_empty & ~i_wr_full & o_armed;
	assign burst_end  = o_rd_en & (word_cnt == burst_cnt_t'(BURST_LEN - 1));

	always_comb
	begin
		state_nxt = state;
		case (state)
			ST_IDLE:
				if (calib_q[1] && fval_q[0] && i_burst_ready && o_armed)
					state_nxt = ST_PTR;
			ST_PTR:
				if (i_alloc_done)
					state_nxt = ST_WR;
			ST_WR:
				if (burst_end || frame_over || !o_armed)
					state_nxt = ST_CMD_WAIT;
			ST_CMD_WAIT:
				if (i_cmd_empty)
					state_nxt = ST_CMD;
			ST_CMD:
				state_nxt = ST_CHK;      // one cycle
			ST_CHK:
				state_nxt = (frame_over || !o_armed) ? ST_IDLE : ST_WR;
			default:
				state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state         <= ST_IDLE;
			o_alloc_start <= 1'b0;
			word_cnt      <= '0;
			burst_idx     <= '0;
		end
		else
		begin
			state         <= state_nxt;
			o_alloc_start <= (state == ST_IDLE) && (state_nxt == ST_PTR); // first ST_PTR cycle
			if (state == ST_IDLE && state_nxt == ST_PTR)
				burst_idx <= '0;             // new frame
			else if (state == ST_CHK && word_cnt != '0)
				burst_idx <= burst_idx + 1'b1;
			if (state == ST_CHK)
				word_cnt <= '0;
			else if (o_rd_en)
				word_cnt <= word_cnt + 1'b1;
		end
	end

	// ----------------------------------------------------------------------
	// controller port
	// ----------------------------------------------------------------------
	assign o_wr_en   = o_rd_en;        // fifo word goes straight out
	assign o_wr_data = i_fifo_data;

	assign o_cmd_en        = (state == ST_CMD) && (word_cnt != '0); // skip empty bursts
	assign o_cmd_bl        = burst_len_t'(word_cnt) - burst_len_t'(1);
	assign o_cmd_byte_addr = {{(BYTE_ADDR_W - PTR_W - BURST_ADDR_W - BURST_BYTE_SHIFT){1'b0}},
		i_wr_ptr, burst_idx, {BURST_BYTE_SHIFT{1'b0}}};

	// committed address moves once the controller has taken the command
	assign cmd_drained = cmd_pending & i_cmd_empty & ~cmd_empty_q;

	always_ff @(posedge clk)
	begin
		if (o_cmd_en)
			cmd_idx <= burst_idx;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			cmd_empty_q <= 1'b0;
			cmd_pending <= 1'b0;
			o_wr_addr   <= '0;
		end
		else
		begin
			cmd_empty_q <= i_cmd_empty;
			if (o_cmd_en)
				cmd_pending <= 1'b1;
			else if (cmd_drained)
				cmd_pending <= 1'b0;
			if (!o_armed)
				o_wr_addr <= '0;         // reader sees frame start
			else if (cmd_drained)
				o_wr_addr <= cmd_idx;
		end
	end

endmodule

`default_nettype wire

/* verilog/frame_wr_ptr_alloc.sv */
// picks next write frame in 4 cycles; i_depth must be 1 to 4 and i_rd_ptr steady while o_changing
`timescale 1ns/1ps
`default_nettype none

module frame_wr_ptr_alloc
	import frame_wr_pkg::*;
(
	input  wire                clk,
	input  wire                reset,
	input  wire                i_armed,
	input  wire                i_start,    // one cycle pulse
	input  wire  frame_depth_t i_depth,
	input  wire  frame_ptr_t   i_rd_ptr,
	output logic               o_done,     // new o_wr_ptr valid this cycle
	output frame_ptr_t         o_wr_ptr,
	output logic               o_changing  // reader holds its pointer
);

	logic [3:0]       step;        // one-hot pipeline stage
	logic             hit_rd;      // next slot is the reader frame
	logic             inc_two;
	logic             first_done;  // first frame after arming placed
	frame_depth_t     slot_inc;
	frame_depth_t     next_slot;
	logic [PTR_W+1:0] sum;         // ptr + inc, at most 5
	logic [PTR_W+1:0] depth_x;
	logic [PTR_W+1:0] wrapped;

	// ----------------------------------------------------------------------
	// step sequencer
	// ----------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
			step <= '0;
		else
			step <= {step[2:0], i_start};
	end

	assign o_done     = step[3];
	assign o_changing = |step;

	// ----------------------------------------------------------------------
	// pointer arithmetic
	// ----------------------------------------------------------------------
	assign slot_inc  = frame_depth_t'(o_wr_ptr) + frame_depth_t'(1);
	assign next_slot = (slot_inc >= i_depth) ? '0 : slot_inc; // mod depth

	assign depth_x = {1'b0, i_depth};
	assign sum     = {2'b00, o_wr_ptr} + (inc_two ? 4'd2 : 4'd1);

	// two laps possible when depth is 1
	always_comb
	begin
		if (sum >= (depth_x << 1))
			wrapped = sum - (depth_x << 1);
		else if (sum >= depth_x)
			wrapped = sum - depth_x;
		else
			wrapped = sum;
	end

	always_ff @(posedge clk)
	begin
		if (step[0])
			hit_rd <= (next_slot == {1'b0, i_rd_ptr}); // step 1 compare
		if (step[1])
			inc_two <= hit_rd;                          // step 2 choose
	end

	// step 3 add and wrap
	always_ff @(posedge clk)
	begin
		if (reset || !i_armed)
		begin
			o_wr_ptr   <= '0;
			first_done <= 1'b0;
		end
		else
		begin
			if (step[2] && first_done)
				o_wr_ptr <= wrapped[PTR_W-1:0]; // first frame keeps 0
			if (step[3])
				first_done <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* verilog/frame_wr_top.sv */
// frame buffer write side, all on clk; i_dval must stay low for 3 cycles after each i_fval rise
`timescale 1ns/1ps
`default_nettype none

module frame_wr_top
	import frame_wr_pkg::*;
(
	input  wire                clk,
	input  wire                reset,
	input  wire                i_fval,
	input  wire                i_dval,
	input  wire  pixel_t       i_data,
	input  wire                i_stream_en,
	input  wire  frame_depth_t i_frame_depth,   // taken while stream disabled
	input  wire  frame_ptr_t   i_rd_ptr,
	input  wire                i_calib_done,
	input  wire                i_cmd_empty,
	input  wire                i_wr_full,
	output wire                o_buf_full,
	output wire                o_buf_overflow,
	output wire                o_stream_armed,
	output wire  frame_ptr_t   o_wr_ptr,
	output wire                o_wr_ptr_changing,
	output wire  burst_addr_t  o_wr_addr,
	output wire                o_cmd_en,
	output wire  burst_len_t   o_cmd_bl,
	output wire  byte_addr_t   o_cmd_byte_addr,
	output wire                o_wr_en,
	output wire  pixel_t       o_wr_data
);

	wire          flush;
	wire          rd_en;
	pixel_t       fifo_dout;
	wire          fifo_empty;
	wire          burst_ready;
	frame_depth_t depth;        // latched frame depth
	wire          alloc_start;
	wire          alloc_done;

	// ----------------------------------------------------------------------
	// pixel buffer, burst writer, frame pointer
	// ----------------------------------------------------------------------
	frame_wr_front_fifo u_fifo (
		.clk           (clk),
		.reset         (reset),
		.i_flush       (flush),
		.i_fval        (i_fval),
		.i_dval        (i_dval),
		.i_armed       (o_stream_armed),
		.i_data        (i_data),
		.i_rd_en       (rd_en),
		.o_dout        (fifo_dout),
		.o_empty       (fifo_empty),
		.o_burst_ready (burst_ready),
		.o_full        (o_buf_full),
		.o_overflow    (o_buf_overflow)
	);

	frame_wr_burst_ctrl u_ctrl (
		.clk             (clk),
		.reset           (reset),
		.i_fval          (i_fval),
		.i_stream_en     (i_stream_en),
		.i_frame_depth   (i_frame_depth),
		.i_calib_done    (i_calib_done),
		.i_fifo_empty    (fifo_empty),
		.i_burst_ready   (burst_ready),
		.i_fifo_data     (fifo_dout),
		.i_alloc_done    (alloc_done),
		.i_wr_ptr        (o_wr_ptr),
		.i_cmd_empty     (i_cmd_empty),
		.i_wr_full       (i_wr_full),
		.o_armed         (o_stream_armed),
		.o_depth         (depth),
		.o_flush         (flush),
		.o_rd_en         (rd_en),
		.o_alloc_start   (alloc_start),
		.o_wr_en         (o_wr_en),
		.o_wr_data       (o_wr_data),
		.o_cmd_en        (o_cmd_en),
		.o_cmd_bl        (o_cmd_bl),
		.o_cmd_byte_addr (o_cmd_byte_addr),
		.o_wr_addr       (o_wr_addr)
	);

	frame_wr_ptr_alloc u_alloc (
		.clk        (clk),
		.reset      (reset),
		.i_armed    (o_stream_armed),
		.i_start    (alloc_start),
		.i_depth    (depth),
		.i_rd_ptr   (i_rd_ptr),
		.o_done     (alloc_done),
		.o_wr_ptr   (o_wr_ptr),
		.o_changing (o_wr_ptr_changing)
	);

endmodule

`default_nettype wire

/* testbench/frame_wr_props.sv */
// checks run on clk with reset high as disable; the model assumes i_rd_ptr steady while pointer changes
`timescale 1ns/1ps
`default_nettype none

module frame_wr_props
	import frame_wr_pkg::*;
(
	input wire               clk,
	input wire               reset,
	input wire               i_fval,
	input wire               i_stream_en,
	input wire frame_depth_t i_frame_depth,
	input wire frame_ptr_t   i_rd_ptr,
	input wire               i_cmd_empty,
	input wire               i_wr_full,
	input wire               o_buf_overflow,
	input wire               o_stream_armed,
	input wire frame_ptr_t   o_wr_ptr,
	input wire               o_wr_ptr_changing,
	input wire burst_addr_t  o_wr_addr,
	input wire               o_cmd_en,
	input wire burst_len_t   o_cmd_bl,
	input wire byte_addr_t   o_cmd_byte_addr,
	input wire               o_wr_en,
	input wire pixel_t       o_wr_data
);

	int           err_cnt = 0;  // read by the testbench top
	pixel_t       exp_data;     // next pixel expected in this frame
	int           wr_cnt;       // writes since last command
	burst_addr_t  exp_idx;      // burst index expected on next command
	frame_depth_t dep;          // depth as latched while stopped
	frame_ptr_t   old_ptr;      // pointer before the allocation
	frame_ptr_t   rd_cap;       // reader frame when the change began
	logic         chg_q;
	logic         first_seen;   // a frame was placed since arming
	frame_ptr_t   exp_ptr;
	burst_addr_t  last_idx;     // index of the last command sent
	logic         cmd_out;      // command sent, controller not drained yet
	logic         empty_q;

	// ----------------------------------------------------------------------
	// reference model
	// ----------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			exp_data   <= '0;
			wr_cnt     <= 0;
			exp_idx    <= '0;
			dep        <= frame_depth_t'(DEPTH_DEFAULT);
			old_ptr    <= '0;
			rd_cap     <= '0;
			chg_q      <= 1'b0;
			first_seen <= 1'b0;
			last_idx   <= '0;
			cmd_out    <= 1'b0;
			empty_q    <= 1'b0;
		end
		else
		begin
			chg_q <= o_wr_ptr_changing;
			if (o_wr_ptr_changing)
				exp_data <= '0;                   // new frame counts from zero
			else if (o_wr_en)
				exp_data <= exp_data + 1'b1;
			if (o_cmd_en)
				wr_cnt <= 0;
			else if (o_wr_en)
				wr_cnt <= wr_cnt + 1;
			if (o_wr_ptr_changing)
				exp_idx <= '0;
			else if (o_cmd_en)
				exp_idx <= exp_idx + 1'b1;
			if (!i_stream_en)
				dep <= i_frame_depth;
			if (o_wr_ptr_changing && !chg_q)
			begin
				old_ptr <= o_wr_ptr;              // capture before step 3
				rd_cap  <= i_rd_ptr;              // reader frame for the compare
			end
			if (!o_stream_armed)
				first_seen <= 1'b0;
			else if (chg_q && !o_wr_ptr_changing)
				first_seen <= 1'b1;
			empty_q <= i_cmd_empty;
			if (o_cmd_en)
			begin
				last_idx <= exp_idx;
				cmd_out  <= 1'b1;
			end
			else if (i_cmd_empty && !empty_q)
				cmd_out <= 1'b0;                  // controller took it
		end
	end

	// step by one, skip the reader slot, wrap at depth
	always_comb
	begin
		int d;
		int nx;
		d  = int'(dep);
		nx = (int'(old_ptr) + 1) % d;
		if (!first_seen)
			exp_ptr = '0;
		else if (nx == int'(rd_cap))
			exp_ptr = frame_ptr_t'((int'(old_ptr) + 2) % d);
		else
			exp_ptr = frame_ptr_t'(nx);
	end

	// ----------------------------------------------------------------------
	// assertions
	// ----------------------------------------------------------------------
	a_data: assert property (@(posedge clk) disable iff (reset)
		o_wr_en && !o_buf_overflow |-> o_wr_data == exp_data)
		else
		begin
			err_cnt++;
			$error("FAILED %0t o_wr_data got %0h expected %0h",
				$time, o_wr_data, exp_data);
		end

	a_bl: assert property (@(posedge clk) disable iff (reset)
		o_cmd_en |-> (int'(o_cmd_bl) + 1 == wr_cnt) && (wr_cnt <= BURST_LEN))
		else
		begin
			err_cnt++;
			$error("FAILED %0t o_cmd_bl got %0d expected %0d",
				$time, o_cmd_bl, wr_cnt - 1);
		end

	a_idx: assert property (@(posedge clk) disable iff (reset)
		o_cmd_en |-> o_cmd_byte_addr[BURST_BYTE_SHIFT +: BURST_ADDR_W] == exp_idx)
		else
		begin
			err_cnt++;
			$error("FAILED %0t o_cmd_byte_addr index got %0d expected %0d",
				$time, o_cmd_byte_addr[BURST_BYTE_SHIFT +: BURST_ADDR_W], exp_idx);
		end

	a_frame: assert property (@(posedge clk) disable iff (reset)
		o_cmd_en |-> o_cmd_byte_addr[BURST_BYTE_SHIFT+BURST_ADDR_W +: PTR_W] == o_wr_ptr
			&& o_cmd_byte_addr[BURST_BYTE_SHIFT-1:0] == '0)
		else
		begin
			err_cnt++;
			$error("command address has a wrong frame field or low bits");
		end

	a_ptr: assert property (@(posedge clk) disable iff (reset)
		$fell(o_wr_ptr_changing) && o_stream_armed |-> o_wr_ptr == exp_ptr)
		else
		begin
			err_cnt++;
			$error("FAILED %0t o_wr_ptr got %0d expected %0d",
				$time, o_wr_ptr, exp_ptr);
		end

	// four cycles of change per allocation
	a_chg: assert property (@(posedge clk) disable iff (reset)
		$rose(o_wr_ptr_changing) |-> o_wr_ptr_changing[*4] ##1 !o_wr_ptr_changing)
		else
		begin
			err_cnt++;
			$error("pointer change flag did not stay high for exactly 4 cycles");
		end

	a_waddr: assert property (@(posedge clk) disable iff (reset)
		cmd_out && i_cmd_empty && !empty_q && i_stream_en && o_stream_armed
			|=> o_wr_addr == last_idx)
		else
		begin
			err_cnt++;
			$error("FAILED %0t o_wr_addr got %0d expected %0d",
				$time, o_wr_addr, last_idx);
		end

	a_cmd_hs: assert property (@(posedge clk) disable iff (reset)
		o_cmd_en |-> !o_wr_en && $past(i_cmd_empty))
		else
		begin
			err_cnt++;
			$error("command issued with a write or without cmd fifo empty");
		end

	a_full: assert property (@(posedge clk) disable iff (reset)
		o_wr_en |-> !i_wr_full)
		else
		begin
			err_cnt++;
			$error("write pushed while the write fifo was full");
		end

	a_disarm: assert property (@(posedge clk) disable iff (reset)
		!o_stream_armed |-> !o_wr_en
			&& ($past(o_stream_armed) || (o_wr_ptr == '0 && o_wr_addr == '0)))
		else
		begin
			err_cnt++;
			$error("write or nonzero pointer or address while the stream is disarmed");
		end

	// arming only from an fval rise seen while enabled
	a_arm: assert property (@(posedge clk) disable iff (reset)
		$rose(o_stream_armed) |-> $past(i_fval, 2) && !$past(i_fval, 3) && $past(i_stream_en))
		else
		begin
			err_cnt++;
			$error("stream armed without a frame start while enabled");
		end

	a_en: assert property (@(posedge clk) disable iff (reset)
		!i_stream_en |=> !o_stream_armed)
		else
		begin
			err_cnt++;
			$error("stream stayed armed after enable dropped");
		end

	a_sticky: assert property (@(posedge clk) disable iff (reset)
		o_buf_overflow && o_stream_armed |=> o_buf_overflow)
		else
		begin
			err_cnt++;
			$error("overflow flag cleared while the stream was armed");
		end

endmodule

bind frame_wr_top frame_wr_props props0 (
	.clk               (clk),
	.reset             (reset),
	.i_fval            (i_fval),
	.i_stream_en       (i_stream_en),
	.i_frame_depth     (i_frame_depth),
	.i_rd_ptr          (i_rd_ptr),
	.i_cmd_empty       (i_cmd_empty),
	.i_wr_full         (i_wr_full),
	.o_buf_overflow    (o_buf_overflow),
	.o_stream_armed    (o_stream_armed),
	.o_wr_ptr          (o_wr_ptr),
	.o_wr_ptr_changing (o_wr_ptr_changing),
	.o_wr_addr         (o_wr_addr),
	.o_cmd_en          (o_cmd_en),
	.o_cmd_bl          (o_cmd_bl),
	.o_cmd_byte_addr   (o_cmd_byte_addr),
	.o_wr_en           (o_wr_en),
	.o_wr_data         (o_wr_data)
);

`default_nettype wire

/* testbench/frame_wr_tb.sv */
// frames of 17 to 100 words with gaps between them; the bound property module does the checking
`timescale 1ns/1ps
`default_nettype none

module frame_wr_tb;
	import frame_wr_pkg::*;

	localparam int NUM_FRAMES = 12;
	localparam int MAX_LEN    = 100;
	localparam int WD_CYCLES  = NUM_FRAMES * MAX_LEN * 8;

	logic         clk;
	logic         reset;
	logic         i_fval;
	logic         i_dval;
	pixel_t       i_data;
	logic         i_stream_en;
	frame_depth_t i_frame_depth;
	frame_ptr_t   i_rd_ptr;
	logic         i_calib_done;
	logic         i_cmd_empty;
	logic         i_wr_full;
	wire          o_buf_full;
	wire          o_buf_overflow;
	wire          o_stream_armed;
	frame_ptr_t   o_wr_ptr;
	wire          o_wr_ptr_changing;
	burst_addr_t  o_wr_addr;
	wire          o_cmd_en;
	burst_len_t   o_cmd_bl;
	byte_addr_t   o_cmd_byte_addr;
	wire          o_wr_en;
	pixel_t       o_wr_data;

	logic [15:0]  frame_lfsr;   // frame lengths and dval gaps
	logic [15:0]  bg_lfsr;      // stalls, cmd delays, reader pointer
	int           full_mode;    // 0 off, 1 random, 2 held high
	int           cmd_delay;
	logic         cmd_hit;
	int           cmd_count;
	logic         full_seen;
	int           other_errs;

	frame_wr_top dut0 (.*);

	always #50 clk = ~clk;

	// ----------------------------------------------------------------------
	// random source
	// ----------------------------------------------------------------------
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic frame_bits(input int n, output int v);
		v = 0;
		repeat (n)
		begin
			frame_lfsr = lfsr_next(frame_lfsr);
			v = (v << 1) | frame_lfsr[0];
		end
	endtask

	task automatic bg_bits(input int n, output int v);
		v = 0;
		repeat (n)
		begin
			bg_lfsr = lfsr_next(bg_lfsr);
			v = (v << 1) | bg_lfsr[0];
		end
	endtask

	// ----------------------------------------------------------------------
	// memory controller model and reader pointer
	// ----------------------------------------------------------------------
	always @(posedge clk)
	begin
		int r;
		#5;
		if (cmd_delay > 0)
		begin
			cmd_delay--;
			if (cmd_delay == 0)
				i_cmd_empty = 1'b1;
		end
		if (cmd_hit)
		begin
			i_cmd_empty = 1'b0;         // command now queued
			bg_bits(3, r);
			cmd_delay = r + 1;
		end
		cmd_hit = o_cmd_en;
		bg_bits(2, r);
		i_wr_full = (full_mode == 2) || (full_mode == 1 && r == 0);
		if (!o_wr_ptr_changing)
		begin
			bg_bits(2, r);
			i_rd_ptr = frame_ptr_t'(r);
		end
	end

	always @(negedge clk)
	begin
		if (!reset && o_cmd_en)
			cmd_count++;
		if (o_buf_full)
			full_seen = 1'b1;
	end

	// ----------------------------------------------------------------------
	// frame stimulus
	// ----------------------------------------------------------------------
	task automatic send_frame(input int len);
		int pix;
		int g;
		@(posedge clk);
		#5 i_fval = 1'b1;
		i_dval = 1'b0;
		repeat (3) @(posedge clk); // dval quiet while the fifo flushes
		pix = 0;
		while (pix < len)
		begin
			@(posedge clk);
			#5;
			frame_bits(2, g);
			if (g == 0)
				i_dval = 1'b0;
			else
			begin
				i_dval = 1'b1;
				i_data = pixel_t'(pix);
				pix++;
			end
		end
		@(posedge clk);
		#5 i_fval = 1'b0;
		i_dval = 1'b0;
	endtask

	task automatic random_frame();
		int r;
		int len;
		int target;
		frame_bits(6, r);
		len = 17 + r % 44;
		if (len % 16 == 0)
			len++;
		target = cmd_count + (len + 15) / 16;
		send_frame(len);
		wait_cmds(target);
	endtask

	task automatic wait_cmds(input int target);
		while (cmd_count < target || !i_cmd_empty)
			@(posedge clk);
		repeat (10) @(posedge clk);
	endtask

	task automatic restart_stream(input int depth);
		@(posedge clk);
		#5 i_stream_en = 1'b0;
		i_frame_depth = frame_depth_t'(depth);
		repeat (4) @(posedge clk);
		#5 i_stream_en = 1'b1;
	endtask

	initial
	begin
		int total;
		clk           = 1'b0;
		reset         = 1'b1;
		i_fval        = 1'b0;
		i_dval        = 1'b0;
		i_data        = '0;
		i_stream_en   = 1'b0;
		i_frame_depth = 3;
		i_rd_ptr      = '0;
		i_calib_done  = 1'b0;
		i_cmd_empty   = 1'b1;
		i_wr_full     = 1'b0;
		frame_lfsr    = 16'd25084;
		bg_lfsr       = 16'd25084;
		full_mode     = 0;
		cmd_delay     = 0;
		cmd_hit       = 1'b0;
		cmd_count     = 0;
		full_seen     = 1'b0;
		other_errs    = 0;
		repeat (16) @(posedge clk);
		#5 reset = 1'b0;
		i_calib_done = 1'b1;
		repeat (4) @(posedge clk);
		// enable in the middle of a frame, nothing may be written
		#5 i_fval = 1'b1;
		i_dval = 1'b1;
		repeat (10) @(posedge clk);
		#5 i_stream_en = 1'b1;
		repeat (20) @(posedge clk);
		#5 i_fval = 1'b0;
		i_dval = 1'b0;
		repeat (10) @(posedge clk);
		full_mode = 1;
		repeat (5) random_frame();
		restart_stream(4);
		repeat (3) random_frame();
		restart_stream(1);
		repeat (2) random_frame();
		// ------------------------------------------------------------------
		// back-pressure through a long frame
		// ------------------------------------------------------------------
		full_mode = 2;
		total = cmd_count + FIFO_DEPTH / BURST_LEN;
		send_frame(MAX_LEN);
		full_mode = 0;
		wait_cmds(total);
		if (!full_seen)
		begin
			$display("buffer full never rose during the held back-pressure frame");
			other_errs++;
		end
		if (!o_buf_overflow)
		begin
			$display("overflow flag did not rise after pixels were dropped");
			other_errs++;
		end
		restart_stream(2);
		if (o_buf_overflow)
		begin
			$display("overflow flag still set after the stream was disabled");
			other_errs++;
		end
		repeat (10) @(posedge clk);
		total = dut0.props0.err_cnt + other_errs;
		$display("errors: %0d assertion, %0d other, %0d commands seen",
			dut0.props0.err_cnt, other_errs, cmd_count);
		if (total == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		#(WD_CYCLES * 100);
		$display("watchdog expired after %0d cycles, stimulus did not complete", WD_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* frame_wr_top.f */
verilog/frame_wr_pkg.sv
verilog/frame_wr_front_fifo.sv
verilog/frame_wr_burst_ctrl.sv
verilog/frame_wr_ptr_alloc.sv
verilog/frame_wr_top.sv
testbench/frame_wr_props.sv
testbench/frame_wr_tb.sv
